//--- logic/eth_monitor_pkg.sv
package eth_monitor_pkg;

    // stream geometry
    localparam int DATAPATH_WIDTH = 32;
    localparam int KEEP_WIDTH     = 2;

    // register port geometry
    localparam int REG_DATA_WIDTH = 40;
    localparam int REG_ADDR_WIDTH = 16;

    // capture memory, length needs one extra bit to hold a full buffer
    localparam int CAPTURE_DEPTH      = 1024;
    localparam int CAPTURE_ADDR_WIDTH = 10;
    localparam int CAPTURE_LEN_WIDTH  = 11;

    // register map
    localparam logic [REG_ADDR_WIDTH-1:0] REG_PKT_COUNT   = 16'h0000;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CAPTURE_ARM = 16'h0001;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CAPTURE_LEN = 16'h0002;
    // addresses with this bit set read the capture memory
    localparam int REG_MEM_WINDOW_BIT = 15;

    typedef struct packed {
        logic [DATAPATH_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0]     keep;
        logic                      valid;
        logic                      abort;
        logic                      last;
    } eth_beat_t;

    // only valid beats are stored, so valid is not kept
    typedef struct packed {
        logic [DATAPATH_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0]     keep;
        logic                      abort;
        logic                      last;
    } capture_row_t;

    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [REG_ADDR_WIDTH-1:0] addr;
    } reg_req_t;

    typedef struct packed {
        logic                      done;
        logic [REG_DATA_WIDTH-1:0] rdata;
    } reg_rsp_t;

    typedef enum logic [1:0] {CAP_IDLE, CAP_ARMED, CAP_CAPTURING} capture_state_t;

    typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_DONE} mem_read_state_t;

endpackage

//--- logic/eth_stream_tap.sv
`timescale 1ns/1ns

module eth_stream_tap (
    input  logic                                       i_clk_stream,
    input  logic                                       i_rst_n,
    input  eth_monitor_pkg::eth_beat_t                 i_stream,
    output eth_monitor_pkg::eth_beat_t                 o_stream,
    output logic [eth_monitor_pkg::REG_DATA_WIDTH-1:0] o_pkt_count
);

    logic [eth_monitor_pkg::DATAPATH_WIDTH-1:0] data_q;
    logic [eth_monitor_pkg::KEEP_WIDTH-1:0]     keep_q;
    logic                                       valid_q;
    logic                                       abort_q;
    logic                                       last_q;
    logic [eth_monitor_pkg::REG_DATA_WIDTH-1:0] pkt_count_q;

    // control bits of the passthrough stage
    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            abort_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= i_stream.valid;
            abort_q <= i_stream.abort;
            last_q  <= i_stream.last;
        end
    end

    always_ff @(posedge i_clk_stream) begin
        data_q <= i_stream.data;
        keep_q <= i_stream.keep;
    end

    assign o_stream = '{data: data_q, keep: keep_q, valid: valid_q, abort: abort_q, last: last_q};

    // a packet counts once its last beat has left the stage, aborted ones too
    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pkt_count_q <= '0;
        end else if (valid_q && last_q && (pkt_count_q != '1)) begin
            pkt_count_q <= pkt_count_q + 1'b1;
        end
    end

    assign o_pkt_count = pkt_count_q;

    // the stream source never marks an end of packet on an empty cycle
    last_needs_valid_a: assert property (
        @(posedge i_clk_stream) disable iff (!i_rst_n)
        i_stream.last |-> i_stream.valid
    );

endmodule

//--- logic/pkt_capture.sv
`timescale 1ns/1ns

module pkt_capture (
    input  logic                                           i_clk_stream,
    input  logic                                           i_rst_n,
    input  eth_monitor_pkg::eth_beat_t                     i_beat,
    input  logic                                           i_arm,
    output logic                                           o_busy,
    output logic                                           o_wr_en,
    output logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] o_wr_addr,
    output eth_monitor_pkg::capture_row_t                  o_wr_row,
    output logic [eth_monitor_pkg::CAPTURE_LEN_WIDTH-1:0]  o_capture_len
);

    localparam logic [eth_monitor_pkg::CAPTURE_LEN_WIDTH-1:0] LEN_FULL =
        eth_monitor_pkg::CAPTURE_LEN_WIDTH'(eth_monitor_pkg::CAPTURE_DEPTH);

    eth_monitor_pkg::capture_state_t               state;
    logic                                          bus_idle;
    logic                                          wr_en_q;
    logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] wr_addr_q;
    eth_monitor_pkg::capture_row_t                 wr_row_q;
    logic [eth_monitor_pkg::CAPTURE_LEN_WIDTH-1:0]  capture_len_q;

    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= eth_monitor_pkg::CAP_IDLE;
            bus_idle      <= 1'b1;
            wr_en_q       <= 1'b0;
            wr_addr_q     <= '0;
            capture_len_q <= '0;
        end else begin
            wr_en_q <= 1'b0;
            // bus is idle between a last beat and the next valid one
            if (i_beat.valid) begin
                bus_idle <= i_beat.last;
            end
            case (state)
                eth_monitor_pkg::CAP_IDLE: begin
                    if (i_arm) begin
                        state <= eth_monitor_pkg::CAP_ARMED;
                    end
                end
                eth_monitor_pkg::CAP_ARMED: begin
                    // only a beat that opens a packet starts the capture
                    if (bus_idle && i_beat.valid) begin
                        wr_en_q       <= 1'b1;
                        wr_addr_q     <= '0;
                        capture_len_q <= eth_monitor_pkg::CAPTURE_LEN_WIDTH'(1);
                        state         <= i_beat.last ? eth_monitor_pkg::CAP_IDLE
                                                     : eth_monitor_pkg::CAP_CAPTURING;
                    end
                end
                eth_monitor_pkg::CAP_CAPTURING: begin
                    if (i_beat.valid) begin
                        // beats past the end of the memory are dropped
                        if (capture_len_q != LEN_FULL) begin
                            wr_en_q       <= 1'b1;
                            wr_addr_q     <= capture_len_q[eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0];
                            capture_len_q <= capture_len_q + 1'b1;
                        end
                        if (i_beat.last) begin
                            state <= eth_monitor_pkg::CAP_IDLE;
                        end
                    end
                end
                default: state <= eth_monitor_pkg::CAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk_stream) begin
        if (i_beat.valid) begin
            wr_row_q.data  <= i_beat.data;
            wr_row_q.keep  <= i_beat.keep;
            wr_row_q.abort <= i_beat.abort;
            wr_row_q.last  <= i_beat.last;
        end
    end

    // stay busy until the final row has gone into the memory
    assign o_busy        = (state != eth_monitor_pkg::CAP_IDLE) || wr_en_q;
    assign o_wr_en       = wr_en_q;
    assign o_wr_addr     = wr_addr_q;
    assign o_wr_row      = wr_row_q;
    assign o_capture_len = capture_len_q;

    len_in_range_a: assert property (
        @(posedge i_clk_stream) disable iff (!i_rst_n)
        capture_len_q <= LEN_FULL
    );

    // a write seen in idle can only be the row that closed the capture
    no_write_from_idle_a: assert property (
        @(posedge i_clk_stream) disable iff (!i_rst_n)
        (wr_en_q && (state == eth_monitor_pkg::CAP_IDLE)) |-> wr_row_q.last
    );

endmodule

//--- logic/capture_ram.sv
`timescale 1ns/1ns

module capture_ram (
    input  logic                                           i_clk_stream,
    input  logic                                           i_wr_en,
    input  logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] i_wr_addr,
    input  eth_monitor_pkg::capture_row_t                  i_wr_row,
    input  logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] i_rd_addr,
    output eth_monitor_pkg::capture_row_t                  o_rd_row
);

    // 36-bit rows fit one block RAM per 1024 entries
    eth_monitor_pkg::capture_row_t mem [eth_monitor_pkg::CAPTURE_DEPTH];
    eth_monitor_pkg::capture_row_t rd_row_q;

    always_ff @(posedge i_clk_stream) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_row;
        end
    end

    // registered read, row is available one cycle after the address
    always_ff @(posedge i_clk_stream) begin
        rd_row_q <= mem[i_rd_addr];
    end

    assign o_rd_row = rd_row_q;

endmodule

//--- logic/monitor_regs.sv
`timescale 1ns/1ns

module monitor_regs (
    input  logic                                           i_clk_stream,
    input  logic                                           i_rst_n,
    input  eth_monitor_pkg::reg_req_t                      i_reg_req,
    output eth_monitor_pkg::reg_rsp_t                      o_reg_rsp,
    input  logic [eth_monitor_pkg::REG_DATA_WIDTH-1:0]     i_pkt_count,
    input  logic                                           i_busy,
    input  logic [eth_monitor_pkg::CAPTURE_LEN_WIDTH-1:0]  i_capture_len,
    output logic                                           o_arm,
    output logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] o_rd_addr,
    input  eth_monitor_pkg::capture_row_t                  i_rd_row
);

    eth_monitor_pkg::mem_read_state_t               rd_state;
    logic                                           done_q;
    logic [eth_monitor_pkg::REG_DATA_WIDTH-1:0]     rdata_q;
    logic [eth_monitor_pkg::REG_DATA_WIDTH-1:0]     reg_value;
    logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] rd_addr_q;
    logic                                           accept;
    logic                                           mem_sel;

    // a new request is taken only after the previous done has gone
    assign accept  = (i_reg_req.read || i_reg_req.write) && !done_q &&
                     (rd_state == eth_monitor_pkg::RD_IDLE);
    assign mem_sel = i_reg_req.addr[eth_monitor_pkg::REG_MEM_WINDOW_BIT];

    // reads win if both request bits are up
    assign o_arm = accept && !i_reg_req.read && i_reg_req.write &&
                   (i_reg_req.addr == eth_monitor_pkg::REG_CAPTURE_ARM);

    always_comb begin
        case (i_reg_req.addr)
            eth_monitor_pkg::REG_PKT_COUNT:   reg_value = i_pkt_count;
            eth_monitor_pkg::REG_CAPTURE_ARM: reg_value = eth_monitor_pkg::REG_DATA_WIDTH'(i_busy);
            eth_monitor_pkg::REG_CAPTURE_LEN: begin
                reg_value = eth_monitor_pkg::REG_DATA_WIDTH'(i_capture_len);
            end
            default:                          reg_value = '0;
        endcase
    end

    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_state <= eth_monitor_pkg::RD_IDLE;
            done_q   <= 1'b0;
            rdata_q  <= '0;
        end else begin
            done_q  <= 1'b0;
            rdata_q <= '0;
            case (rd_state)
                eth_monitor_pkg::RD_IDLE: begin
                    if (accept) begin
                        if (i_reg_req.read && mem_sel) begin
                            rd_state <= eth_monitor_pkg::RD_WAIT;
                        end else begin
                            // writes and plain registers answer right away
                            done_q <= 1'b1;
                            if (i_reg_req.read) begin
                                rdata_q <= reg_value;
                            end
                        end
                    end
                end
                eth_monitor_pkg::RD_WAIT: begin
                    // memory registers the row during this cycle
                    rd_state <= eth_monitor_pkg::RD_DONE;
                end
                eth_monitor_pkg::RD_DONE: begin
                    rd_state <= eth_monitor_pkg::RD_IDLE;
                    done_q   <= 1'b1;
                    // upper four bits stay zero
                    rdata_q  <= eth_monitor_pkg::REG_DATA_WIDTH'(i_rd_row);
                end
                default: rd_state <= eth_monitor_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk_stream) begin
        if (accept && mem_sel) begin
            rd_addr_q <= i_reg_req.addr[eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0];
        end
    end

    assign o_rd_addr = rd_addr_q;
    assign o_reg_rsp = '{done: done_q, rdata: rdata_q};

    done_single_pulse_a: assert property (
        @(posedge i_clk_stream) disable iff (!i_rst_n)
        done_q |=> !done_q
    );

    // an arm pulse is answered by a write done with zero data in the next cycle
    arm_then_done_a: assert property (
        @(posedge i_clk_stream) disable iff (!i_rst_n)
        o_arm |=> (done_q && (rdata_q == '0))
    );

endmodule

//--- logic/eth_stream_monitor.sv
`timescale 1ns/1ns

module eth_stream_monitor (
    input  logic                       i_clk_stream,
    input  logic                       i_rst_n,
    input  eth_monitor_pkg::eth_beat_t i_stream,
    output eth_monitor_pkg::eth_beat_t o_stream,
    input  eth_monitor_pkg::reg_req_t  i_reg_req,
    output eth_monitor_pkg::reg_rsp_t  o_reg_rsp
);

    eth_monitor_pkg::eth_beat_t                     tap_beat;
    logic [eth_monitor_pkg::REG_DATA_WIDTH-1:0]     pkt_count;
    logic                                           arm;
    logic                                           busy;
    logic [eth_monitor_pkg::CAPTURE_LEN_WIDTH-1:0]  capture_len;
    logic                                           wr_en;
    logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] wr_addr;
    eth_monitor_pkg::capture_row_t                  wr_row;
    logic [eth_monitor_pkg::CAPTURE_ADDR_WIDTH-1:0] rd_addr;
    eth_monitor_pkg::capture_row_t                  rd_row;

    eth_stream_tap eth_stream_tap_u (
        .i_clk_stream (i_clk_stream),
        .i_rst_n      (i_rst_n),
        .i_stream     (i_stream),
        .o_stream     (tap_beat),
        .o_pkt_count  (pkt_count)
    );

    assign o_stream = tap_beat;

    pkt_capture pkt_capture_u (
        .i_clk_stream  (i_clk_stream),
        .i_rst_n       (i_rst_n),
        .i_beat        (tap_beat),
        .i_arm         (arm),
        .o_busy        (busy),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_row      (wr_row),
        .o_capture_len (capture_len)
    );

    capture_ram capture_ram_u (
        .i_clk_stream (i_clk_stream),
        .i_wr_en      (wr_en),
        .i_wr_addr    (wr_addr),
        .i_wr_row     (wr_row),
        .i_rd_addr    (rd_addr),
        .o_rd_row     (rd_row)
    );

    monitor_regs monitor_regs_u (
        .i_clk_stream  (i_clk_stream),
        .i_rst_n       (i_rst_n),
        .i_reg_req     (i_reg_req),
        .o_reg_rsp     (o_reg_rsp),
        .i_pkt_count   (pkt_count),
        .i_busy        (busy),
        .i_capture_len (capture_len),
        .o_arm         (arm),
        .o_rd_addr     (rd_addr),
        .i_rd_row      (rd_row)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic o_clk_stream,
    output logic o_rst_n
);

    // 20 ns period
    initial begin
        o_clk_stream = 1'b0;
        forever #10 o_clk_stream = ~o_clk_stream;
    end

    // reset held low for 5 rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk_stream);
        o_rst_n <= 1'b1;
    end

endmodule

//--- tb/eth_stream_monitor_tb.sv
`timescale 1ns/1ns

module eth_stream_monitor_tb;

    localparam int MAX_CYCLES = 4000;
    localparam int RW = eth_monitor_pkg::REG_DATA_WIDTH;
    localparam int AW = eth_monitor_pkg::REG_ADDR_WIDTH;

    logic                        clk_stream;
    logic                        rst_n;
    eth_monitor_pkg::eth_beat_t  stream_in;
    eth_monitor_pkg::eth_beat_t  stream_out;
    eth_monitor_pkg::reg_req_t   reg_req;
    eth_monitor_pkg::reg_rsp_t   reg_rsp;

    logic [31:0]                 rng_state = 32'h82ec;
    logic [RW-1:0]               exp_pkt_count = '0;
    eth_monitor_pkg::eth_beat_t  sent_beats[$];
    int                          error_count = 0;
    int                          cycle_count = 0;

    tb_clock_gen clock_gen_u (
        .o_clk_stream (clk_stream),
        .o_rst_n      (rst_n)
    );

    eth_stream_monitor i_eth_stream_monitor (
        .i_clk_stream (clk_stream),
        .i_rst_n      (rst_n),
        .i_stream     (stream_in),
        .o_stream     (stream_out),
        .i_reg_req    (reg_req),
        .o_reg_rsp    (reg_rsp)
    );

    task fail_run();
        error_count++;
        $display("Done: errors found");
        $fatal(1, "stopping at first failure");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // last only ever rides on a valid beat
    function automatic eth_monitor_pkg::eth_beat_t random_beat();
        eth_monitor_pkg::eth_beat_t beat;
        logic [31:0] r;
        r = next_rand();
        beat.data  = next_rand();
        beat.keep  = r[1:0];
        beat.valid = r[2];
        beat.abort = r[3];
        beat.last  = r[4] & r[2];
        return beat;
    endfunction

    task automatic check_beat(input eth_monitor_pkg::eth_beat_t got,
                              input eth_monitor_pkg::eth_beat_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic check_row(input eth_monitor_pkg::capture_row_t got,
                             input eth_monitor_pkg::capture_row_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic check_rdata(input logic [RW-1:0] got, input logic [RW-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_stream);
    endtask

    // control bits are driven high through reset and must not reach the output
    task automatic check_reset_outputs();
        @(negedge clk_stream);
        check_beat(stream_out, '0, "stream output during reset");
    endtask

    // drives on the current edge and keeps the packet count model up to date
    task automatic drive_beat(input eth_monitor_pkg::eth_beat_t beat);
        stream_in <= beat;
        if (beat.valid && beat.last) begin
            exp_pkt_count = exp_pkt_count + 1'b1;
        end
    endtask

    task automatic send_packet(input int len, input logic abort_end);
        eth_monitor_pkg::eth_beat_t beat;
        logic [31:0] r;
        int i;
        sent_beats.delete();
        for (i = 0; i < len; i++) begin
            r = next_rand();
            beat.data  = next_rand();
            beat.keep  = r[1:0];
            beat.valid = 1'b1;
            beat.last  = (i == len - 1);
            beat.abort = beat.last && abort_end;
            @(posedge clk_stream);
            drive_beat(beat);
            sent_beats.push_back(beat);
        end
        @(posedge clk_stream);
        drive_beat('0);
    endtask

    // latency counts cycles from the edge that first samples the request
    task automatic reg_access(input logic is_write, input logic [AW-1:0] reg_addr,
                              output logic [RW-1:0] rdata, output int latency);
        int waited;
        @(posedge clk_stream);
        reg_req <= '{read: !is_write, write: is_write, addr: reg_addr};
        @(negedge clk_stream);
        waited = 1;
        while (!reg_rsp.done) begin
            if (waited == 8) begin
                $display("register access to address %h timed out without done", reg_addr);
                fail_run();
            end
            @(negedge clk_stream);
            waited++;
        end
        rdata   = reg_rsp.rdata;
        latency = waited - 1;
        @(posedge clk_stream);
        reg_req <= '0;
    endtask

    task automatic read_expect(input logic [AW-1:0] reg_addr, input logic [RW-1:0] exp,
                               input string what);
        logic [RW-1:0] rdata;
        int latency;
        int exp_latency;
        exp_latency = reg_addr[eth_monitor_pkg::REG_MEM_WINDOW_BIT] ? 3 : 1;
        reg_access(1'b0, reg_addr, rdata, latency);
        check_rdata(rdata, exp, what);
        check_rdata(RW'(latency), RW'(exp_latency), {what, " done latency"});
    endtask

    task automatic write_reg(input logic [AW-1:0] reg_addr, input string what);
        logic [RW-1:0] rdata;
        int latency;
        reg_access(1'b1, reg_addr, rdata, latency);
        check_rdata(rdata, '0, {what, " write rdata"});
        check_rdata(RW'(latency), RW'(1), {what, " done latency"});
    endtask

    task automatic test_passthrough();
        eth_monitor_pkg::eth_beat_t beats[50];
        int k;
        for (k = 0; k <= 50; k++) begin
            @(posedge clk_stream);
            if (k < 50) begin
                beats[k] = random_beat();
                drive_beat(beats[k]);
            end else begin
                drive_beat('0);
            end
            @(negedge clk_stream);
            if (k > 0) begin
                check_beat(stream_out, beats[k-1], $sformatf("passthrough beat %0d", k - 1));
            end
        end
    endtask

    task automatic test_pkt_counter();
        int i;
        // packet 3 ends with abort and still counts
        for (i = 0; i < 6; i++) begin
            send_packet(1 + int'(next_rand() % 8), i == 3);
        end
        idle_cycles(2);
        read_expect(eth_monitor_pkg::REG_PKT_COUNT, exp_pkt_count, "count after six packets");
        for (i = 0; i < 3; i++) begin
            send_packet(1 + int'(next_rand() % 8), 1'b0);
        end
        idle_cycles(2);
        read_expect(eth_monitor_pkg::REG_PKT_COUNT, exp_pkt_count, "count after nine packets");
    endtask

    task automatic test_arm_status();
        int len;
        write_reg(eth_monitor_pkg::REG_CAPTURE_ARM, "arm");
        read_expect(eth_monitor_pkg::REG_CAPTURE_ARM, RW'(1), "status once armed");
        len = 2 + int'(next_rand() % 10);
        send_packet(len, 1'b0);
        idle_cycles(4);
        read_expect(eth_monitor_pkg::REG_CAPTURE_ARM, '0, "status after captured packet");
        read_expect(eth_monitor_pkg::REG_CAPTURE_LEN, RW'(len), "length of captured packet");
    endtask

    task automatic test_capture();
        eth_monitor_pkg::capture_row_t exp_row;
        logic [RW-1:0] rdata;
        logic [31:0] r;
        int latency;
        int len;
        int i;
        // arm lands while the first packet is on the bus
        fork
            send_packet(24, 1'b0);
            begin
                idle_cycles(6);
                write_reg(eth_monitor_pkg::REG_CAPTURE_ARM, "arm mid packet");
            end
        join
        idle_cycles(4);
        read_expect(eth_monitor_pkg::REG_CAPTURE_ARM, RW'(1), "still armed after skipped packet");
        r   = next_rand();
        len = 8 + int'(next_rand() % 25);
        send_packet(len, r[0]);
        idle_cycles(4);
        read_expect(eth_monitor_pkg::REG_CAPTURE_LEN, RW'(len), "captured length");
        read_expect(eth_monitor_pkg::REG_CAPTURE_ARM, '0, "status after capture");
        for (i = 0; i < len; i++) begin
            reg_access(1'b0, AW'(16'h8000 + i), rdata, latency);
            exp_row = '{data: sent_beats[i].data, keep: sent_beats[i].keep,
                        abort: sent_beats[i].abort, last: sent_beats[i].last};
            check_row(eth_monitor_pkg::capture_row_t'(rdata[35:0]), exp_row,
                      $sformatf("captured row %0d", i));
            check_rdata(rdata >> 36, '0, $sformatf("upper bits of row %0d", i));
            check_rdata(RW'(latency), RW'(3), $sformatf("done latency of row %0d", i));
        end
    endtask

    task automatic test_unmapped();
        read_expect(16'h0003, '0, "read of address 3");
        read_expect(16'h1234, '0, "read of address 1234");
        write_reg(eth_monitor_pkg::REG_PKT_COUNT, "write to count");
        read_expect(eth_monitor_pkg::REG_PKT_COUNT, exp_pkt_count, "count after write");
        write_reg(eth_monitor_pkg::REG_CAPTURE_LEN, "write to length");
        idle_cycles(2);
        read_expect(eth_monitor_pkg::REG_CAPTURE_ARM, '0, "status after length write");
    endtask

    always @(posedge clk_stream) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("simulation did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

    initial begin
        // control bits held high while reset is asserted
        stream_in       = '0;
        stream_in.valid = 1'b1;
        stream_in.abort = 1'b1;
        stream_in.last  = 1'b1;
        reg_req         = '0;
        check_reset_outputs();
        wait (rst_n === 1'b1);
        stream_in <= '0;
        idle_cycles(2);
        test_passthrough();
        test_pkt_counter();
        test_arm_status();
        test_capture();
        test_unmapped();
        idle_cycles(2);
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

//--- eth_stream_monitor.f
logic/eth_monitor_pkg.sv
logic/eth_stream_tap.sv
logic/pkt_capture.sv
logic/capture_ram.sv
logic/monitor_regs.sv
logic/eth_stream_monitor.sv
tb/tb_clock_gen.sv
tb/eth_stream_monitor_tb.sv
